//--- sources.f
design/rename_pkg.sv
design/inst_decoder.sv
design/rename_regfile.sv
design/dispatch_queue.sv
design/reorder_buffer.sv
design/rename_core_top.sv
dv/rename_core_chk.sv
dv/rename_core_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rename_core_tb -f sources.f -o rename_core_sim

./obj_dir/rename_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- dv/rename_core_tb.sv
module rename_core_tb
    import rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED       = 66718;
    localparam int WAIT_LIMIT = 2000;

    logic      clk;
    logic      rst;
    logic      inst_valid;
    logic      inst_ready;
    inst_t     inst;
    logic      commit_valid;
    logic      commit_ready;
    reg_name_t commit_rd;
    logic      commit_wen;
    data_t     commit_data;
    logic      bp_on;

    data_t     model [32];
    inst_t     stim_q [$];
    string     exp_name [$];
    reg_name_t exp_rd [$];
    logic      exp_wen [$];
    data_t     exp_data [$];
    int        issued;
    int        checked;

    rename_core_top #(.ROB_DEPTH(8), .DQ_DEPTH(4)) u_dut (
        .clk, .rst, .inst_valid, .inst_ready, .inst,
        .commit_valid, .commit_ready, .commit_rd, .commit_wen, .commit_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input string field,
                               input data_t exp, input data_t act);
        report_failure($sformatf("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
                                 name, field, exp, act));
    endtask

    function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_name_t rd,
                                    reg_name_t rs1, reg_name_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_alu(int unsigned kind, reg_name_t rd, reg_name_t rs1,
                                      reg_name_t rs2);
        case (kind)
            0:       return enc_r(7'h00, 3'b000, rd, rs1, rs2);   // add
            1:       return enc_r(7'h20, 3'b000, rd, rs1, rs2);   // sub
            default: return enc_r(7'h00, 3'b100, rd, rs1, rs2);   // xor
        endcase
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_name_t rd, reg_name_t rs1);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, reg_name_t rs1, reg_name_t rs2);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // executes one word in program order and queues the commit it must produce
    function automatic void ref_exec(input inst_t w, input string name);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        data_t      a;
        data_t      b;
        data_t      res;
        logic       alu;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = model[w[19:15]];
        b   = model[w[24:20]];
        res = '0;
        alu = 1'b1;
        if (opc == 7'b0110011 && f3 == 3'b000 && f7 == 7'h00) begin
            res = a + b;
        end else if (opc == 7'b0110011 && f3 == 3'b000 && f7 == 7'h20) begin
            res = a - b;
        end else if (opc == 7'b0110011 && f3 == 3'b100 && f7 == 7'h00) begin
            res = a ^ b;
        end else if (opc == 7'b0010011 && f3 == 3'b000) begin
            res = a + {{20{w[31]}}, w[31:20]};
        end else begin
            alu = 1'b0;
            if (opc == 7'b0100011 && f3 == 3'b010) begin
                res = b;                                          // a store shows its rs2 value
            end
        end
        exp_name.push_back(name);
        exp_rd.push_back(alu ? w[11:7] : 5'd0);
        exp_wen.push_back(alu && w[11:7] != 5'd0);
        exp_data.push_back(res);
        if (alu && w[11:7] != 5'd0) begin
            model[w[11:7]] = res;
        end
        issued++;
    endfunction

    function automatic void issue(input inst_t w, input string name);
        ref_exec(w, name);
        stim_q.push_back(w);
    endfunction

    // random mix over x0..x7, unsupported words come out as lui
    function automatic inst_t random_word();
        reg_name_t   rd;
        reg_name_t   rs1;
        reg_name_t   rs2;
        int unsigned kind;
        rd   = reg_name_t'($urandom_range(0, 7));
        rs1  = reg_name_t'($urandom_range(0, 7));
        rs2  = reg_name_t'($urandom_range(0, 7));
        kind = $urandom_range(0, 5);
        if (kind < 3) begin
            return enc_alu(kind, rd, rs1, rs2);
        end else if (kind == 3) begin
            return enc_i(12'($urandom), rd, rs1);
        end else if (kind == 4) begin
            return enc_s(12'($urandom), rs1, rs2);
        end
        return {20'($urandom), rd, 7'b0110111};
    endfunction

    task automatic send_word(input inst_t word);
        int waited;
        waited = 0;
        inst       = word;
        inst_valid = 1'b1;
        while (!inst_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout: inst_ready stayed low, the front end is stuck");
            end
        end
        @(negedge clk);                                           // word taken at the rising edge
        inst_valid = 1'b0;
        if (bp_on) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end
    endtask

    task automatic drive_queue();
        while (stim_q.size() > 0) begin
            send_word(stim_q.pop_front());
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data.size() > 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout: instructions were sent but never committed");
            end
        end
    endtask

    initial begin
        commit_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (bp_on && $urandom_range(0, 5) == 0) begin
                commit_ready = 1'b0;
                repeat ($urandom_range(1, 12)) @(negedge clk);
            end
            commit_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        string     name;
        reg_name_t e_rd;
        logic      e_wen;
        data_t     e_data;
        if (!rst && commit_valid && commit_ready) begin
            assert (exp_data.size() > 0) begin
                name   = exp_name.pop_front();
                e_rd   = exp_rd.pop_front();
                e_wen  = exp_wen.pop_front();
                e_data = exp_data.pop_front();
                assert (commit_rd == e_rd)
                else value_error(name, "commit_rd", data_t'(e_rd), data_t'(commit_rd));
                assert (commit_wen == e_wen)
                else value_error(name, "commit_wen", data_t'(e_wen), data_t'(commit_wen));
                assert (commit_data == e_data)
                else value_error(name, "commit_data", e_data, commit_data);
                checked++;
            end else begin
                report_failure("a commit arrived with no instruction outstanding");
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        bp_on      = 1'b0;
        issued     = 0;
        checked    = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 1; i < 8; i++) begin
            issue(enc_i(12'($urandom), reg_name_t'(i), 5'd0), "independent");
        end
        drive_queue();
        wait_drain();
        for (int i = 8; i < 16; i++) begin
            issue(enc_alu($urandom_range(0, 2), reg_name_t'(i), reg_name_t'($urandom_range(1, 7)),
                          reg_name_t'($urandom_range(1, 7))), "independent");
        end
        drive_queue();

        for (int n = 0; n < 12; n++) begin                        // 36 dependent ops, well past 8 tags
            issue(enc_i(12'($urandom), 5'd9, 5'd9), "dep_chain");
            issue(enc_alu(0, 5'd10, 5'd10, 5'd9), "dep_chain");
            issue(enc_alu(2, 5'd11, 5'd10, 5'd9), "dep_chain");
        end
        drive_queue();

        issue(enc_i(12'h123, 5'd0, 5'd1), "x0_handling");
        issue(enc_alu(0, 5'd0, 5'd1, 5'd2), "x0_handling");
        issue(enc_alu(0, 5'd12, 5'd0, 5'd0), "x0_handling");
        issue(enc_alu(2, 5'd13, 5'd0, 5'd1), "x0_handling");
        drive_queue();

        issue(enc_s(12'h005, 5'd1, 5'd2), "store_nop");           // rd slot of the word names x5
        issue(enc_s(12'h7e3, 5'd3, 5'd4), "store_nop");
        issue({20'h12345, 5'd3, 7'b0110111}, "store_nop");
        issue(enc_r(7'h00, 3'b001, 5'd4, 5'd2, 5'd1), "store_nop");
        issue({12'h000, 5'd1, 3'b000, 5'd5, 7'b1100011}, "store_nop");
        issue(enc_i(12'h000, 5'd14, 5'd3), "store_nop");
        issue(enc_i(12'h000, 5'd15, 5'd4), "store_nop");
        issue(enc_i(12'h000, 5'd16, 5'd5), "store_nop");
        drive_queue();
        wait_drain();

        bp_on = 1'b1;
        for (int n = 0; n < 400; n++) begin
            issue(random_word(), "random_backpressure");
        end
        drive_queue();
        wait_drain();
        bp_on = 1'b0;

        issue(enc_i(12'h111, 5'd6, 5'd0), "write_after_write");
        issue(enc_i(12'h222, 5'd6, 5'd0), "write_after_write");
        issue(enc_alu(1, 5'd6, 5'd1, 5'd2), "write_after_write");
        issue(enc_alu(0, 5'd7, 5'd6, 5'd0), "write_after_write");
        drive_queue();
        wait_drain();

        if (exp_data.size() == 0 && checked == issued) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure($sformatf("only %0d of %0d instructions committed", checked, issued));
        end
    end

endmodule

//--- dv/rename_core_chk.sv
module rename_core_chk
    import rename_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      inst_ready,
    input logic      commit_valid,
    input logic      commit_ready,
    input reg_name_t commit_rd,
    input logic      commit_wen,
    input data_t     commit_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // a cycle with reset sampled high clears the buffer, so the next cycle cannot commit
    a_no_commit_in_reset: assert property (@(posedge clk) $past(rst) |-> !commit_valid)
        else $error("commit_valid high during or right after reset");

    a_commit_held: assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_rd)
            && $stable(commit_wen) && $stable(commit_data))
        else $error("commit signals changed while stalled");

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> !(commit_wen && commit_rd == 5'd0))
        else $error("write enable set for destination x0");

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> inst_ready)
        else $error("inst_ready low in the first cycle after reset");

endmodule

bind rename_core_top rename_core_chk u_chk (
    .clk(clk), .rst(rst), .inst_ready(inst_ready),
    .commit_valid(commit_valid), .commit_ready(commit_ready),
    .commit_rd(commit_rd), .commit_wen(commit_wen), .commit_data(commit_data)
);

//--- design/rename_core_top.sv
module rename_core_top
    import rename_pkg::*;
#(
    parameter  int ROB_DEPTH = 8,
    parameter  int DQ_DEPTH  = 4,
    localparam int TW        = $clog2(ROB_DEPTH)
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    output logic      inst_ready,
    input  inst_t     inst,
    output logic      commit_valid,
    input  logic      commit_ready,
    output reg_name_t commit_rd,
    output logic      commit_wen,
    output data_t     commit_data
);

    logic          dec_valid, dec_ready;
    op_e           dec_op;
    reg_name_t     dec_rs1, dec_rs2, dec_rd;
    imm_t          dec_imm;
    logic [TW-1:0] alloc_tag;
    logic          alloc_ready, alloc;
    logic          ren_valid, ren_ready, ren_src1_pend, ren_src2_pend;
    op_e           ren_op;
    logic [TW-1:0] ren_tag, ren_src1_tag, ren_src2_tag;
    reg_name_t     ren_rd;
    imm_t          ren_imm;
    data_t         ren_src1_data, ren_src2_data;
    logic          dq_valid, dq_ready, dq_src1_pend, dq_src2_pend;
    op_e           dq_op;
    logic [TW-1:0] dq_tag, dq_src1_tag, dq_src2_tag;
    reg_name_t     dq_rd;
    imm_t          dq_imm;
    data_t         dq_src1_data, dq_src2_data;
    logic          cm_fire, cm_wen;
    logic [TW-1:0] cm_tag;
    reg_name_t     cm_rd;
    data_t         cm_data;

    inst_decoder u_dec (
        .clk, .rst, .inst_valid, .inst_ready, .inst,
        .dec_valid, .dec_ready, .dec_op, .dec_rs1, .dec_rs2, .dec_rd, .dec_imm
    );

    rename_regfile #(.ROB_DEPTH(ROB_DEPTH)) u_rf (
        .clk, .rst,
        .dec_valid, .dec_ready, .dec_op, .dec_rs1, .dec_rs2, .dec_rd, .dec_imm,
        .alloc_tag, .alloc_ready, .alloc,
        .ren_valid, .ren_ready, .ren_op, .ren_tag, .ren_rd, .ren_imm,
        .ren_src1_pend, .ren_src1_tag, .ren_src1_data,
        .ren_src2_pend, .ren_src2_tag, .ren_src2_data,
        .cm_fire, .cm_tag, .cm_rd, .cm_wen, .cm_data
    );

    dispatch_queue #(.DQ_DEPTH(DQ_DEPTH), .ROB_DEPTH(ROB_DEPTH)) u_dq (
        .clk, .rst,
        .ren_valid, .ren_ready, .ren_op, .ren_tag, .ren_rd, .ren_imm,
        .ren_src1_pend, .ren_src1_tag, .ren_src1_data,
        .ren_src2_pend, .ren_src2_tag, .ren_src2_data,
        .dq_valid, .dq_ready, .dq_op, .dq_tag, .dq_rd, .dq_imm,
        .dq_src1_pend, .dq_src1_tag, .dq_src1_data,
        .dq_src2_pend, .dq_src2_tag, .dq_src2_data,
        .cm_fire, .cm_tag, .cm_data
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk, .rst, .alloc, .alloc_tag, .alloc_ready,
        .dq_valid, .dq_ready, .dq_op, .dq_tag, .dq_rd, .dq_imm,
        .dq_src1_pend, .dq_src1_tag, .dq_src1_data,
        .dq_src2_pend, .dq_src2_tag, .dq_src2_data,
        .cm_fire, .cm_tag, .cm_rd, .cm_wen, .cm_data,
        .commit_valid, .commit_ready, .commit_rd, .commit_wen, .commit_data
    );

endmodule

//--- design/reorder_buffer.sv
module reorder_buffer
    import rename_pkg::*;
#(
    parameter  int ROB_DEPTH = 1 << TAG_W,
    localparam int TW        = $clog2(ROB_DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          alloc,
    output logic [TW-1:0] alloc_tag,
    output logic          alloc_ready,
    input  logic          dq_valid,
    output logic          dq_ready,
    input  op_e           dq_op,
    input  logic [TW-1:0] dq_tag,
    input  reg_name_t     dq_rd,
    input  imm_t          dq_imm,
    input  logic          dq_src1_pend,
    input  logic [TW-1:0] dq_src1_tag,
    input  data_t         dq_src1_data,
    input  logic          dq_src2_pend,
    input  logic [TW-1:0] dq_src2_tag,
    input  data_t         dq_src2_data,
    output logic          cm_fire,
    output logic [TW-1:0] cm_tag,
    output reg_name_t     cm_rd,
    output logic          cm_wen,
    output data_t         cm_data,
    output logic          commit_valid,
    input  logic          commit_ready,
    output reg_name_t     commit_rd,
    output logic          commit_wen,
    output data_t         commit_data
);

    typedef logic [TW-1:0] tag_t;

    logic      busy     [ROB_DEPTH];
    logic      done     [ROB_DEPTH];
    op_e       e_op     [ROB_DEPTH];
    reg_name_t e_rd     [ROB_DEPTH];
    imm_t      e_imm    [ROB_DEPTH];
    logic      e_s1_rdy [ROB_DEPTH];
    tag_t      e_s1_tag [ROB_DEPTH];
    data_t     e_s1_val [ROB_DEPTH];
    logic      e_s2_rdy [ROB_DEPTH];
    tag_t      e_s2_tag [ROB_DEPTH];
    data_t     e_s2_val [ROB_DEPTH];
    data_t     e_result [ROB_DEPTH];
    tag_t      head;
    logic [TW:0] cnt;
    logic      ex_fire;
    tag_t      ex_idx;
    data_t     ex_result;
    logic      s1_rdy;
    logic      s2_rdy;
    data_t     s1_val;
    data_t     s2_val;

    // a finished producer covers the head committing this cycle as well
    function automatic void resolve(input logic pend, input tag_t tag, input data_t data,
                                    output logic rdy, output data_t val);
        rdy = 1'b1;
        val = data;
        if (pend) begin
            if (busy[tag] && done[tag]) begin
                val = e_result[tag];
            end else if (ex_fire && ex_idx == tag) begin
                val = ex_result;
            end else begin
                rdy = 1'b0;
            end
        end
    endfunction

    assign alloc_ready = cnt != (TW+1)'(ROB_DEPTH);
    assign dq_ready    = 1'b1;                                  // slots are reserved at rename

    assign commit_valid = busy[head] && done[head];
    assign commit_rd    = e_rd[head];
    assign commit_wen   = writes_rd(e_op[head], e_rd[head]);
    assign commit_data  = e_result[head];
    assign cm_fire      = commit_valid && commit_ready;
    assign cm_tag       = head;
    assign cm_rd        = commit_rd;
    assign cm_wen       = commit_wen;
    assign cm_data      = commit_data;

    always_comb begin
        resolve(dq_src1_pend, dq_src1_tag, dq_src1_data, s1_rdy, s1_val);
        resolve(dq_src2_pend, dq_src2_tag, dq_src2_data, s2_rdy, s2_val);
    end

    // scan from the youngest down so the oldest ready entry wins
    always_comb begin
        tag_t idx;
        ex_fire = 1'b0;
        ex_idx  = head;
        for (int k = ROB_DEPTH - 1; k >= 0; k--) begin
            idx = tag_t'(head + k);
            if (busy[idx] && !done[idx] && e_s1_rdy[idx] && e_s2_rdy[idx]) begin
                ex_fire = 1'b1;
                ex_idx  = idx;
            end
        end
    end

    always_comb begin
        case (e_op[ex_idx])
            op_add:  ex_result = e_s1_val[ex_idx] + e_s2_val[ex_idx];
            op_sub:  ex_result = e_s1_val[ex_idx] - e_s2_val[ex_idx];
            op_xor:  ex_result = e_s1_val[ex_idx] ^ e_s2_val[ex_idx];
            op_addi: ex_result = e_s1_val[ex_idx] + e_imm[ex_idx];
            op_sw:   ex_result = e_s2_val[ex_idx];                // store reports its rs2 value
            default: ex_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            alloc_tag <= '0;
            cnt       <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
                done[i] <= 1'b0;
            end
        end else begin
            if (alloc) begin
                alloc_tag <= alloc_tag + 1'b1;
            end
            if (cm_fire) begin
                head       <= head + 1'b1;
                busy[head] <= 1'b0;
            end
            cnt <= cnt + (TW+1)'(alloc) - (TW+1)'(cm_fire);
            if (ex_fire) begin
                done[ex_idx] <= 1'b1;
            end
            if (dq_valid) begin
                busy[dq_tag] <= 1'b1;
                done[dq_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (ex_fire && !e_s1_rdy[i] && e_s1_tag[i] == ex_idx) begin
                e_s1_rdy[i] <= 1'b1;
                e_s1_val[i] <= ex_result;
            end
            if (ex_fire && !e_s2_rdy[i] && e_s2_tag[i] == ex_idx) begin
                e_s2_rdy[i] <= 1'b1;
                e_s2_val[i] <= ex_result;
            end
        end
        if (ex_fire) begin
            e_result[ex_idx] <= ex_result;
        end
        if (dq_valid) begin
            e_op[dq_tag]     <= dq_op;
            e_rd[dq_tag]     <= dq_rd;
            e_imm[dq_tag]    <= dq_imm;
            e_s1_rdy[dq_tag] <= s1_rdy;
            e_s1_tag[dq_tag] <= dq_src1_tag;
            e_s1_val[dq_tag] <= s1_val;
            e_s2_rdy[dq_tag] <= s2_rdy;
            e_s2_tag[dq_tag] <= dq_src2_tag;
            e_s2_val[dq_tag] <= s2_val;
        end
    end

endmodule

//--- design/dispatch_queue.sv
module dispatch_queue
    import rename_pkg::*;
#(
    parameter  int DQ_DEPTH  = 4,
    parameter  int ROB_DEPTH = 1 << TAG_W,
    localparam int TW        = $clog2(ROB_DEPTH),
    localparam int PW        = $clog2(DQ_DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          ren_valid,
    output logic          ren_ready,
    input  op_e           ren_op,
    input  logic [TW-1:0] ren_tag,
    input  reg_name_t     ren_rd,
    input  imm_t          ren_imm,
    input  logic          ren_src1_pend,
    input  logic [TW-1:0] ren_src1_tag,
    input  data_t         ren_src1_data,
    input  logic          ren_src2_pend,
    input  logic [TW-1:0] ren_src2_tag,
    input  data_t         ren_src2_data,
    output logic          dq_valid,
    input  logic          dq_ready,
    output op_e           dq_op,
    output logic [TW-1:0] dq_tag,
    output reg_name_t     dq_rd,
    output imm_t          dq_imm,
    output logic          dq_src1_pend,
    output logic [TW-1:0] dq_src1_tag,
    output data_t         dq_src1_data,
    output logic          dq_src2_pend,
    output logic [TW-1:0] dq_src2_tag,
    output data_t         dq_src2_data,
    input  logic          cm_fire,
    input  logic [TW-1:0] cm_tag,
    input  data_t         cm_data
);

    typedef logic [TW-1:0] tag_t;
    typedef logic [PW-1:0] ptr_t;

    op_e       q_op      [DQ_DEPTH];
    tag_t      q_tag     [DQ_DEPTH];
    reg_name_t q_rd      [DQ_DEPTH];
    imm_t      q_imm     [DQ_DEPTH];
    logic      q_s1_pend [DQ_DEPTH];
    tag_t      q_s1_tag  [DQ_DEPTH];
    data_t     q_s1_data [DQ_DEPTH];
    logic      q_s2_pend [DQ_DEPTH];
    tag_t      q_s2_tag  [DQ_DEPTH];
    data_t     q_s2_data [DQ_DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    logic [PW:0] count;
    logic      push;
    logic      pop;

    function automatic logic cm_hit(logic p, tag_t t);
        return p && cm_fire && (cm_tag == t);
    endfunction

    assign ren_ready = count != (PW+1)'(DQ_DEPTH);
    assign dq_valid  = count != '0;
    assign push      = ren_valid && ren_ready;
    assign pop       = dq_valid && dq_ready;

    assign dq_op        = q_op[rd_ptr];
    assign dq_tag       = q_tag[rd_ptr];
    assign dq_rd        = q_rd[rd_ptr];
    assign dq_imm       = q_imm[rd_ptr];
    assign dq_src1_pend = q_s1_pend[rd_ptr];
    assign dq_src1_tag  = q_s1_tag[rd_ptr];
    assign dq_src1_data = q_s1_data[rd_ptr];
    assign dq_src2_pend = q_s2_pend[rd_ptr];
    assign dq_src2_tag  = q_s2_tag[rd_ptr];
    assign dq_src2_data = q_s2_data[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PW+1)'(push) - (PW+1)'(pop);
        end
    end

    // held entries capture commits so a tag never outlives its producer's slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < DQ_DEPTH; i++) begin
            if (cm_hit(q_s1_pend[i], q_s1_tag[i])) begin
                q_s1_pend[i] <= 1'b0;
                q_s1_data[i] <= cm_data;
            end
            if (cm_hit(q_s2_pend[i], q_s2_tag[i])) begin
                q_s2_pend[i] <= 1'b0;
                q_s2_data[i] <= cm_data;
            end
        end
        if (push) begin
            q_op[wr_ptr]      <= ren_op;
            q_tag[wr_ptr]     <= ren_tag;
            q_rd[wr_ptr]      <= ren_rd;
            q_imm[wr_ptr]     <= ren_imm;
            q_s1_tag[wr_ptr]  <= ren_src1_tag;
            q_s2_tag[wr_ptr]  <= ren_src2_tag;
            q_s1_pend[wr_ptr] <= ren_src1_pend && !cm_hit(ren_src1_pend, ren_src1_tag);
            q_s2_pend[wr_ptr] <= ren_src2_pend && !cm_hit(ren_src2_pend, ren_src2_tag);
            q_s1_data[wr_ptr] <= cm_hit(ren_src1_pend, ren_src1_tag) ? cm_data : ren_src1_data;
            q_s2_data[wr_ptr] <= cm_hit(ren_src2_pend, ren_src2_tag) ? cm_data : ren_src2_data;
        end
    end

endmodule

//--- design/rename_regfile.sv
module rename_regfile
    import rename_pkg::*;
#(
    parameter  int ROB_DEPTH = 1 << TAG_W,
    localparam int TW        = $clog2(ROB_DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          dec_valid,
    output logic          dec_ready,
    input  op_e           dec_op,
    input  reg_name_t     dec_rs1,
    input  reg_name_t     dec_rs2,
    input  reg_name_t     dec_rd,
    input  imm_t          dec_imm,
    input  logic [TW-1:0] alloc_tag,
    input  logic          alloc_ready,
    output logic          alloc,
    output logic          ren_valid,
    input  logic          ren_ready,
    output op_e           ren_op,
    output logic [TW-1:0] ren_tag,
    output reg_name_t     ren_rd,
    output imm_t          ren_imm,
    output logic          ren_src1_pend,
    output logic [TW-1:0] ren_src1_tag,
    output data_t         ren_src1_data,
    output logic          ren_src2_pend,
    output logic [TW-1:0] ren_src2_tag,
    output data_t         ren_src2_data,
    input  logic          cm_fire,
    input  logic [TW-1:0] cm_tag,
    input  reg_name_t     cm_rd,
    input  logic          cm_wen,
    input  data_t         cm_data
);

    typedef logic [TW-1:0] tag_t;

    data_t vals [32];
    tag_t  tags [32];
    logic  pend [32];
    logic  dec_fire;
    logic  s1_pend;
    logic  s2_pend;
    data_t s1_data;
    data_t s2_data;

    function automatic logic cm_hit(logic p, tag_t t);
        return p && cm_fire && (cm_tag == t);
    endfunction

    assign dec_ready = (!ren_valid || ren_ready) && alloc_ready;
    assign dec_fire  = dec_valid && dec_ready;
    assign alloc     = dec_fire;

    // x0 is never written or tagged so it reads as a clean zero
    always_comb begin
        s1_pend = pend[dec_rs1];
        s1_data = vals[dec_rs1];
        if (cm_hit(s1_pend, tags[dec_rs1])) begin
            s1_pend = 1'b0;
            s1_data = cm_data;
        end
        s2_pend = pend[dec_rs2];
        s2_data = vals[dec_rs2];
        if (cm_hit(s2_pend, tags[dec_rs2])) begin
            s2_pend = 1'b0;
            s2_data = cm_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                vals[i] <= '0;
                pend[i] <= 1'b0;
            end
        end else begin
            if (cm_fire && cm_wen) begin
                vals[cm_rd] <= cm_data;
                if (tags[cm_rd] == cm_tag) begin                // a younger rename keeps its pend
                    pend[cm_rd] <= 1'b0;
                end
            end
            if (dec_fire && writes_rd(dec_op, dec_rd)) begin
                tags[dec_rd] <= alloc_tag;
                pend[dec_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= 1'b0;
        end else if (dec_fire) begin
            ren_valid <= 1'b1;
        end else if (ren_ready) begin
            ren_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_fire) begin
            ren_op        <= dec_op;
            ren_tag       <= alloc_tag;
            ren_rd        <= dec_rd;
            ren_imm       <= dec_imm;
            ren_src1_pend <= s1_pend;
            ren_src1_tag  <= tags[dec_rs1];
            ren_src1_data <= s1_data;
            ren_src2_pend <= s2_pend;
            ren_src2_tag  <= tags[dec_rs2];
            ren_src2_data <= s2_data;
        end else begin
            if (cm_hit(ren_src1_pend, ren_src1_tag)) begin  // stalled entry still sees commits
                ren_src1_pend <= 1'b0;
                ren_src1_data <= cm_data;
            end
            if (cm_hit(ren_src2_pend, ren_src2_tag)) begin
                ren_src2_pend <= 1'b0;
                ren_src2_data <= cm_data;
            end
        end
    end

endmodule

//--- design/inst_decoder.sv
module inst_decoder
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      inst_valid,
    output logic      inst_ready,
    input  inst_t     inst,
    output logic      dec_valid,
    input  logic      dec_ready,
    output op_e       dec_op,
    output reg_name_t dec_rs1,
    output reg_name_t dec_rs2,
    output reg_name_t dec_rd,
    output imm_t      dec_imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    imm_t       imm;
    logic       inst_fire;

    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign inst_ready = !dec_valid || dec_ready;
    assign inst_fire  = inst_valid && inst_ready;

    always_comb begin
        op  = op_nop;
        imm = {{20{inst[31]}}, inst[31:20]};                     // I-type by default
        case (opcode)
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    op = op_add;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    op = op_sub;
                end else if (funct3 == 3'b100 && funct7 == 7'b0000000) begin
                    op = op_xor;
                end
            end
            OPC_OPIMM: begin
                if (funct3 == 3'b000) begin
                    op = op_addi;
                end
            end
            OPC_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                if (funct3 == 3'b010) begin
                    op = op_sw;
                end
            end
            default: op = op_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (inst_fire) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // unused register fields go to x0 so they never create a dependency
    always_ff @(posedge clk) begin
        if (inst_fire) begin
            dec_op  <= op;
            dec_rs1 <= (op == op_nop) ? 5'd0 : inst[19:15];
            dec_rs2 <= (op inside {op_add, op_sub, op_xor, op_sw}) ? inst[24:20] : 5'd0;
            dec_rd  <= (op inside {op_add, op_sub, op_xor, op_addi}) ? inst[11:7] : 5'd0;
            dec_imm <= imm;
        end
    end

endmodule

//--- design/rename_pkg.sv
package rename_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_name_t;
    typedef logic [31:0] imm_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [2:0] {
        op_nop,
        op_add,
        op_sub,
        op_xor,
        op_addi,
        op_sw
    } op_e;

    localparam int TAG_W = 3;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // only the ALU ops with a real destination update the register file
    function automatic logic writes_rd(op_e op, reg_name_t rd);
        return (op inside {op_add, op_sub, op_xor, op_addi}) && (rd != 5'd0);
    endfunction

endpackage
